//--- verilog.f
hw/jtag_pkg.sv
hw/scan_pkg.sv
hw/jtag_host.sv
hw/jtag_tap.sv
hw/jtag_data_regs.sv
hw/jtag_subsystem.sv
bench/jtag_tb.sv

//--- Bender.yml
package:
  name: jtag_subsystem

sources:
  # Packages first, jtag_pkg is used by scan_pkg
  - hw/jtag_pkg.sv
  - hw/scan_pkg.sv
  # RTL
  - hw/jtag_host.sv
  - hw/jtag_tap.sv
  - hw/jtag_data_regs.sv
  - hw/jtag_subsystem.sv
  # Testbench
  - target: test
    files:
      - bench/jtag_tb.sv

//--- bench/jtag_tb.sv
`timescale 1ns/10ps

module jtag_tb;
    import jtag_pkg::*;
    import scan_pkg::*;

    localparam int TIMEOUT = 5000;

    // Expected response together with the scratch value the target holds afterwards
    typedef struct packed {
        scan_rsp_t             rsp;
        logic [MAX_DR_LEN-1:0] scratch;
    } model_t;

    logic      clk;
    logic      reset;
    logic      req;
    scan_req_t scan_req;
    logic      ack;
    scan_rsp_t scan_rsp;

    logic [31:0]           lfsr_state;
    logic [MAX_DR_LEN-1:0] model_scratch;
    scan_rsp_t             exp_q[$];
    scan_rsp_t             act_q[$];
    int                    test_errors;
    int                    pass_count;
    int                    fail_count;
    bit                    hung;

    jtag_subsystem dut0
    (
        .clk      (clk),
        .reset    (reset),
        .req      (req),
        .scan_req (scan_req),
        .ack      (ack),
        .scan_rsp (scan_rsp)
    );

    always #10 clk = ~clk;

    // Fibonacci LFSR with taps 32, 22, 2 and 1 that advances one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < n; i++)
        begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    function automatic scan_req_t make_req(input logic [IR_WIDTH-1:0] instr, input int len,
                                           input logic [MAX_DR_LEN-1:0] data);
        scan_req_t r;
        r.instruction = instr;
        r.dr_len = DR_LEN_WIDTH'(len);
        r.dr_out = data;
        return r;
    endfunction

    // Target model: IDCODE, scratch register and the one-bit bypass path
    function automatic model_t predict(input scan_req_t r, input logic [MAX_DR_LEN-1:0] scratch);
        model_t                m;
        logic [MAX_DR_LEN-1:0] mask;
        int                    len;
        len = int'(r.dr_len);
        mask = (len >= MAX_DR_LEN) ? '1 : ((32'h1 << len) - 32'h1);
        m.rsp.ir_in = IR_CAPTURE_VALUE;
        m.scratch = scratch;
        case (r.instruction)
            INSTR_IDCODE:
                m.rsp.dr_in = IDCODE_VALUE & mask;
            INSTR_SCRATCH:
            begin
                m.rsp.dr_in = scratch & mask;
                // A short scan leaves the old upper bits moved down below the new ones
                if (len >= MAX_DR_LEN)
                    m.scratch = r.dr_out;
                else
                    m.scratch = (scratch >> len) | (r.dr_out << (MAX_DR_LEN - len));
            end
            default:
                m.rsp.dr_in = (r.dr_out << 1) & mask;
        endcase
        return m;
    endfunction

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("[ERROR] %s: got %h, expected %h", name, actual, expected);
            test_errors++;
        end
    endtask

    // Compares each captured response with its prediction, in order
    always @(posedge clk)
    begin : compare
        scan_rsp_t actual;
        scan_rsp_t expected;
        while (act_q.size() > 0 && exp_q.size() > 0)
        begin
            actual = act_q.pop_front();
            expected = exp_q.pop_front();
            check("ir_in", 32'(actual.ir_in), 32'(expected.ir_in));
            check("dr_in", actual.dr_in, expected.dr_in);
        end
    end

    // Runs the full four-phase handshake and keeps req high for hold extra cycles after ack
    task automatic do_scan(input scan_req_t r, input int hold);
        model_t    m;
        scan_rsp_t held;
        int        count;
        if (!hung)
        begin
            @(negedge clk);
            scan_req = r;
            req = 1'b1;
            m = predict(r, model_scratch);
            model_scratch = m.scratch;
            exp_q.push_back(m.rsp);
            count = 0;
            while (ack !== 1'b1 && count < TIMEOUT)
            begin
                @(negedge clk);
                count++;
            end
            if (ack !== 1'b1)
            begin
                $display("Timed out waiting for ack to rise");
                hung = 1'b1;
            end
            else
            begin
                act_q.push_back(scan_rsp);
                held = scan_rsp;
                repeat (hold)
                begin
                    @(negedge clk);
                    check("ack", 32'(ack), 32'h1);
                    check("scan_rsp.ir_in", 32'(scan_rsp.ir_in), 32'(held.ir_in));
                    check("scan_rsp.dr_in", scan_rsp.dr_in, held.dr_in);
                end
                req = 1'b0;
                count = 0;
                while (ack !== 1'b0 && count < TIMEOUT)
                begin
                    @(negedge clk);
                    count++;
                end
                if (ack !== 1'b0)
                begin
                    $display("Timed out waiting for ack to fall after req dropped");
                    hung = 1'b1;
                end
            end
        end
    endtask

    task automatic end_test(input string name);
        int count;
        count = 0;
        while (act_q.size() > 0 && count < TIMEOUT)
        begin
            @(negedge clk);
            count++;
        end
        if (act_q.size() > 0)
        begin
            $display("%s: responses were never compared", name);
            hung = 1'b1;
        end
        if (test_errors == 0 && !hung)
        begin
            $display("%s: ok", name);
            pass_count++;
        end
        else
        begin
            $display("%s: %0d mismatches%s", name, test_errors, hung ? ", stopped" : "");
            fail_count++;
        end
        test_errors = 0;
    endtask

    initial
    begin
        logic [IR_WIDTH-1:0] code;
        int                  len;
        clk = 1'b0;
        reset = 1'b1;
        req = 1'b0;
        scan_req = '0;
        lfsr_state = 32'hb03cb16e;
        model_scratch = '0;
        test_errors = 0;
        pass_count = 0;
        fail_count = 0;
        hung = 1'b0;
        repeat (16) @(negedge clk);
        reset = 1'b0;

        @(negedge clk);
        check("ack", 32'(ack), 32'h0);
        do_scan(make_req(INSTR_IDCODE, 32, take_bits(32)), 0);
        end_test("idcode after reset");

        // Each scan reads back what the one before it wrote
        for (int i = 0; i < 8; i++)
        begin
            do_scan(make_req(INSTR_SCRATCH, 32, take_bits(32)), 0);
            do_scan(make_req(INSTR_SCRATCH, 32, take_bits(32)), 0);
        end
        end_test("scratch write and read");

        for (int i = 0; i < 8; i++)
        begin
            if (i % 2 == 0)
                code = INSTR_BYPASS;
            else
            begin
                code = IR_WIDTH'(take_bits(4));
                // Flip the top bit to land on a code with no register behind it
                if (code == INSTR_IDCODE || code == INSTR_SCRATCH || code == INSTR_BYPASS)
                    code = code ^ 4'h8;
            end
            len = take_bits(5) + 1;
            do_scan(make_req(code, len, take_bits(32)), 0);
        end
        end_test("bypass");

        for (int i = 0; i < 10; i++)
        begin
            len = (take_bits(5) % 31) + 1;
            do_scan(make_req(INSTR_SCRATCH, len, take_bits(32)), 0);
        end
        do_scan(make_req(INSTR_SCRATCH, 32, take_bits(32)), 0);
        end_test("short scratch scans");

        do_scan(make_req(INSTR_SCRATCH, 32, take_bits(32)), 20);
        do_scan(make_req(INSTR_IDCODE, 32, take_bits(32)), 0);
        end_test("handshake hold");

        $display("tests ok: %0d, tests with errors: %0d", pass_count, fail_count);
        if (fail_count == 0 && !hung)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

//--- hw/jtag_subsystem.sv
`timescale 1ns/10ps

module jtag_subsystem
(
    input  logic                clk,
    input  logic                reset,
    input  logic                req,
    input  scan_pkg::scan_req_t scan_req,
    output logic                ack,
    output scan_pkg::scan_rsp_t scan_rsp
);
    import jtag_pkg::*;
    import scan_pkg::*;

    jtag_pins_t          pins;
    logic                tdo;
    logic                dr_tdo;
    jtag_state_t         tap_state;
    logic                tck_rise;
    logic [IR_WIDTH-1:0] instruction;

    jtag_host host0
    (
        .clk      (clk),
        .reset    (reset),
        .req      (req),
        .scan_req (scan_req),
        .ack      (ack),
        .scan_rsp (scan_rsp),
        .pins     (pins),
        .tdo      (tdo)
    );

    // The fall strobe is only needed inside the TAP for tdo timing
    jtag_tap tap0
    (
        .clk         (clk),
        .reset       (reset),
        .pins        (pins),
        .tdo         (tdo),
        .tap_state   (tap_state),
        .tck_rise    (tck_rise),
        .tck_fall    (),
        .instruction (instruction),
        .dr_tdo      (dr_tdo)
    );

    jtag_data_regs regs0
    (
        .clk         (clk),
        .reset       (reset),
        .tap_state   (tap_state),
        .tck_rise    (tck_rise),
        .instruction (instruction),
        .shift_in    (pins.tdi),
        .dr_tdo      (dr_tdo)
    );

endmodule

//--- hw/jtag_data_regs.sv
`timescale 1ns/10ps

module jtag_data_regs
(
    input  logic                          clk,
    input  logic                          reset,
    input  jtag_pkg::jtag_state_t         tap_state,
    input  logic                          tck_rise,
    input  logic [jtag_pkg::IR_WIDTH-1:0] instruction,
    input  logic                          shift_in,
    output logic                          dr_tdo
);
    import jtag_pkg::*;

    logic [MAX_DR_LEN-1:0] dr_shift;
    logic [MAX_DR_LEN-1:0] scratch;
    logic                  bypass;

    assign bypass = (instruction != INSTR_IDCODE) && (instruction != INSTR_SCRATCH);
    assign dr_tdo = dr_shift[0];

    // One shift stage shared by all data registers
    always_ff @(posedge clk)
    begin
        if (tck_rise)
        begin
            case (tap_state)
                TAP_CAPTURE_DR:
                begin
                    case (instruction)
                        INSTR_IDCODE:  dr_shift <= IDCODE_VALUE;
                        INSTR_SCRATCH: dr_shift <= scratch;
                        default:       dr_shift <= '0;
                    endcase
                end
                TAP_SHIFT_DR:
                begin
                    // Bypass is a single flop between tdi and tdo
                    if (bypass)
                        dr_shift[0] <= shift_in;
                    else
                        dr_shift <= {shift_in, dr_shift[MAX_DR_LEN-1:1]};
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            scratch <= '0;
        else if (tck_rise && tap_state == TAP_UPDATE_DR && instruction == INSTR_SCRATCH)
            scratch <= dr_shift;
    end

endmodule

//--- hw/jtag_tap.sv
`timescale 1ns/10ps

module jtag_tap
(
    input  logic                          clk,
    input  logic                          reset,
    input  scan_pkg::jtag_pins_t          pins,
    output logic                          tdo,
    output jtag_pkg::jtag_state_t         tap_state,
    output logic                          tck_rise,
    output logic                          tck_fall,
    output logic [jtag_pkg::IR_WIDTH-1:0] instruction,
    input  logic                          dr_tdo
);
    import jtag_pkg::*;

    logic                tck_q;
    logic [IR_WIDTH-1:0] ir_shift;

    // tck is sampled by clk, never used as a clock here
    assign tck_rise = pins.tck && !tck_q;
    assign tck_fall = !pins.tck && tck_q;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            tck_q <= 1'b0;
        else
            tck_q <= pins.tck;
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            tap_state <= TAP_RESET;
        else if (pins.trst)
            tap_state <= TAP_RESET;
        else if (tck_rise)
            tap_state <= tap_next(tap_state, pins.tms);
    end

    // Test-Logic-Reset always brings back the IDCODE instruction
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            instruction <= INSTR_IDCODE;
        else if (pins.trst || tap_state == TAP_RESET)
            instruction <= INSTR_IDCODE;
        else if (tck_rise && tap_state == TAP_UPDATE_IR)
            instruction <= ir_shift;
    end

    always_ff @(posedge clk)
    begin
        if (tck_rise)
        begin
            case (tap_state)
                TAP_CAPTURE_IR: ir_shift <= IR_CAPTURE_VALUE;
                TAP_SHIFT_IR:   ir_shift <= {pins.tdi, ir_shift[IR_WIDTH-1:1]};
                default: ;
            endcase
        end
    end

    // tdo moves on the falling edge so the host sees it settled at the next rise.
    // Outside the shift states it sits at zero in place of a tristate
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            tdo <= 1'b0;
        else if (tck_fall)
        begin
            case (tap_state)
                TAP_SHIFT_IR: tdo <= ir_shift[0];
                TAP_SHIFT_DR: tdo <= dr_tdo;
                default:      tdo <= 1'b0;
            endcase
        end
    end

endmodule

//--- hw/jtag_host.sv
`timescale 1ns/10ps

module jtag_host
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 req,
    input  scan_pkg::scan_req_t  scan_req,
    output logic                 ack,
    output scan_pkg::scan_rsp_t  scan_rsp,
    output scan_pkg::jtag_pins_t pins,
    input  logic                 tdo
);
    import jtag_pkg::*;
    import scan_pkg::*;

    logic [TCK_DIV_WIDTH-1:0] div_count;
    logic                     tck_q;
    logic                     tms_q;
    logic                     tdi_q;
    logic                     tms_nxt;
    logic                     tick_rise;
    logic                     tick_fall;
    logic                     start;
    logic                     ir_done;
    jtag_state_t              state_ff;
    logic [DR_LEN_WIDTH-1:0]  shift_count;
    logic [IR_WIDTH-1:0]      ir_shift;
    logic [MAX_DR_LEN-1:0]    dr_shift;

    // A new scan may only start once the previous ack has been taken down
    assign start = req && !ack;

    // The cycle in which tck is about to toggle
    assign tick_rise = (div_count == '0) && !tck_q;
    assign tick_fall = (div_count == '0) && tck_q;

    // The target is held in reset until the host leaves its own reset state
    assign pins = '{tck: tck_q, tms: tms_q, tdi: tdi_q, trst: (state_ff == TAP_RESET)};

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            div_count <= '0;
            tck_q <= 1'b0;
        end
        else if (div_count == '0)
        begin
            div_count <= TCK_DIV_WIDTH'(TCK_DIVISOR);
            tck_q <= !tck_q;
        end
        else
            div_count <= div_count - 1'b1;
    end

    // The tms value for the next rising edge comes from the host copy of the TAP state
    always_comb
    begin
        case (state_ff)
            TAP_IDLE:
                tms_nxt = start;
            // First pass goes over to the IR column, second pass captures DR
            TAP_SELECT_DR:
                tms_nxt = !ir_done;
            TAP_SHIFT_IR,
            TAP_SHIFT_DR:
                tms_nxt = (shift_count == DR_LEN_WIDTH'(1));
            TAP_PAUSE_IR,
            TAP_PAUSE_DR,
            TAP_EXIT2_IR,
            TAP_EXIT2_DR,
            TAP_UPDATE_IR:
                tms_nxt = 1'b1;
            default:
                tms_nxt = 1'b0;
        endcase
    end

    // Outgoing pins change on the falling edge only
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            tms_q <= 1'b1;
            tdi_q <= 1'b0;
        end
        else if (tick_fall)
        begin
            tms_q <= tms_nxt;
            case (state_ff)
                TAP_SHIFT_IR: tdi_q <= ir_shift[0];
                TAP_SHIFT_DR: tdi_q <= dr_shift[0];
                default:      tdi_q <= 1'b0;
            endcase
        end
    end

    // State, bit counter and handshake all advance on the rising edge
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state_ff <= TAP_RESET;
            shift_count <= '0;
            ir_done <= 1'b0;
            ack <= 1'b0;
        end
        else
        begin
            if (ack && !req)
                ack <= 1'b0;

            if (tick_rise)
            begin
                // Follows the same graph as the target, driven by the tms it sees
                state_ff <= tap_next(state_ff, tms_q);
                case (state_ff)
                    TAP_CAPTURE_IR: shift_count <= DR_LEN_WIDTH'(IR_WIDTH);
                    TAP_CAPTURE_DR: shift_count <= scan_req.dr_len;
                    TAP_SHIFT_IR,
                    TAP_SHIFT_DR:   shift_count <= shift_count - 1'b1;
                    TAP_UPDATE_IR:  ir_done <= 1'b1;
                    TAP_UPDATE_DR:
                    begin
                        ir_done <= 1'b0;
                        ack <= 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

    // Shift registers send LSB first and collect tdo from the top
    always_ff @(posedge clk)
    begin
        if (tick_rise)
        begin
            case (state_ff)
                TAP_CAPTURE_IR:
                    ir_shift <= scan_req.instruction;
                TAP_SHIFT_IR:
                    ir_shift <= {tdo, ir_shift[IR_WIDTH-1:1]};
                // Bits above dr_len are cleared so the result comes out right-aligned
                TAP_CAPTURE_DR:
                    dr_shift <= scan_req.dr_out & ~({MAX_DR_LEN{1'b1}} << scan_req.dr_len);
                TAP_SHIFT_DR:
                    dr_shift <= (dr_shift >> 1)
                        | (MAX_DR_LEN'(tdo) << (scan_req.dr_len - 1'b1));
                TAP_UPDATE_DR:
                    scan_rsp <= '{ir_in: ir_shift, dr_in: dr_shift};
                default: ;
            endcase
        end
    end

endmodule

//--- hw/scan_pkg.sv
package scan_pkg;

    // Wide enough to hold a length of 1 to MAX_DR_LEN
    localparam int DR_LEN_WIDTH = $clog2(jtag_pkg::MAX_DR_LEN + 1);

    // tck toggles once every TCK_DIVISOR+1 clk cycles
    localparam int TCK_DIVISOR = 7;
    localparam int TCK_DIV_WIDTH = $clog2(TCK_DIVISOR + 1);

    typedef struct packed {
        logic [jtag_pkg::IR_WIDTH-1:0]   instruction;
        logic [DR_LEN_WIDTH-1:0]         dr_len;
        logic [jtag_pkg::MAX_DR_LEN-1:0] dr_out;
    } scan_req_t;

    // dr_in is right-aligned to the requested dr_len
    typedef struct packed {
        logic [jtag_pkg::IR_WIDTH-1:0]   ir_in;
        logic [jtag_pkg::MAX_DR_LEN-1:0] dr_in;
    } scan_rsp_t;

    typedef struct packed {
        logic tck;
        logic tms;
        logic tdi;
        logic trst;
    } jtag_pins_t;

endpackage

//--- hw/jtag_pkg.sv
package jtag_pkg;

    // IEEE 1149.1 TAP controller states
    typedef enum logic [3:0] {
        TAP_RESET,
        TAP_IDLE,
        TAP_SELECT_DR,
        TAP_CAPTURE_DR,
        TAP_SHIFT_DR,
        TAP_EXIT1_DR,
        TAP_PAUSE_DR,
        TAP_EXIT2_DR,
        TAP_UPDATE_DR,
        TAP_SELECT_IR,
        TAP_CAPTURE_IR,
        TAP_SHIFT_IR,
        TAP_EXIT1_IR,
        TAP_PAUSE_IR,
        TAP_EXIT2_IR,
        TAP_UPDATE_IR
    } jtag_state_t;

    localparam int IR_WIDTH = 4;
    localparam logic [IR_WIDTH-1:0] IR_CAPTURE_VALUE = 4'b0001;

    localparam logic [IR_WIDTH-1:0] INSTR_IDCODE = 4'h1;
    localparam logic [IR_WIDTH-1:0] INSTR_SCRATCH = 4'h2;
    // Any code other than IDCODE and SCRATCH also selects bypass
    localparam logic [IR_WIDTH-1:0] INSTR_BYPASS = 4'hf;

    // Bit 0 is always set in a 1149.1 device identifier
    localparam logic [31:0] IDCODE_VALUE = 32'h2b17_a0c3;

    localparam int MAX_DR_LEN = 32;

    // The TAP state graph advances once per rising tck
    function automatic jtag_state_t tap_next(input jtag_state_t state, input logic tms);
        case (state)
            TAP_RESET:      tap_next = tms ? TAP_RESET : TAP_IDLE;
            TAP_IDLE:       tap_next = tms ? TAP_SELECT_DR : TAP_IDLE;
            TAP_SELECT_DR:  tap_next = tms ? TAP_SELECT_IR : TAP_CAPTURE_DR;
            TAP_CAPTURE_DR: tap_next = tms ? TAP_EXIT1_DR : TAP_SHIFT_DR;
            TAP_SHIFT_DR:   tap_next = tms ? TAP_EXIT1_DR : TAP_SHIFT_DR;
            TAP_EXIT1_DR:   tap_next = tms ? TAP_UPDATE_DR : TAP_PAUSE_DR;
            TAP_PAUSE_DR:   tap_next = tms ? TAP_EXIT2_DR : TAP_PAUSE_DR;
            TAP_EXIT2_DR:   tap_next = tms ? TAP_UPDATE_DR : TAP_SHIFT_DR;
            TAP_UPDATE_DR:  tap_next = tms ? TAP_SELECT_DR : TAP_IDLE;
            TAP_SELECT_IR:  tap_next = tms ? TAP_RESET : TAP_CAPTURE_IR;
            TAP_CAPTURE_IR: tap_next = tms ? TAP_EXIT1_IR : TAP_SHIFT_IR;
            TAP_SHIFT_IR:   tap_next = tms ? TAP_EXIT1_IR : TAP_SHIFT_IR;
            TAP_EXIT1_IR:   tap_next = tms ? TAP_UPDATE_IR : TAP_PAUSE_IR;
            TAP_PAUSE_IR:   tap_next = tms ? TAP_EXIT2_IR : TAP_PAUSE_IR;
            TAP_EXIT2_IR:   tap_next = tms ? TAP_UPDATE_IR : TAP_SHIFT_IR;
            TAP_UPDATE_IR:  tap_next = tms ? TAP_SELECT_DR : TAP_IDLE;
        endcase
    endfunction

endpackage
